/* Bender.yml */
package:
  name: pcs_tx

sources:
  - files:
      - design/pcs_pkg.sv
      - design/gearbox_sequencer.sv
      - design/tx_scrambler.sv
      - design/tx_gearbox.sv
      - design/pcs_tx_top.sv
  - target: test
    files:
      - dv/pcs_tx_tb.sv

/* design/gearbox_sequencer.sv */
`timescale 1ns/1ps

module gearbox_sequencer (
    input  logic                  i_clk,
    input  logic                  i_reset,
    output logic                  o_pause,
    output pcs_pkg::gearbox_ctrl_t o_ctrl
);

    import pcs_pkg::*;

    logic [SEQ_WIDTH-1:0] seq_q;
    gearbox_ctrl_t        ctrl_q;

    // free running count 0..SEQ_LAST over a 33-cycle period.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            seq_q <= '0;
        end else if (seq_q == SEQ_LAST) begin
            seq_q <= '0; // wrap.
        end else begin
            seq_q <= seq_q + 1'b1;
        end
    end

    // upstream must hold its word in this slot.
    assign o_pause = (seq_q == SEQ_LAST);

    // The scrambler adds one cycle, so the gearbox gets the
    // sequence that belongs to the word it is about to load.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q.seq   <= seq_q;
            ctrl_q.pause <= o_pause;
        end
    end

    assign o_ctrl = ctrl_q;

    a_seq_in_range: assert property (
        @(posedge i_clk) disable iff (i_reset)
        seq_q <= SEQ_LAST
    ) else $error("gearbox sequence counter beyond SEQ_LAST.");

    a_pause_at_last: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_ctrl.pause |-> (o_ctrl.seq == SEQ_LAST)
    ) else $error("delayed pause outside the SEQ_LAST slot.");

endmodule

/* design/pcs_pkg.sv */
package pcs_pkg;

    // datapath widths.
    localparam int DATA_WIDTH   = 32;
    localparam int HEADER_WIDTH = 2;
    localparam int BLOCK_WIDTH  = 2 * DATA_WIDTH + HEADER_WIDTH; // one 66-bit block.

    // gearbox sequence.
    localparam int SEQ_WIDTH = 6;
    localparam logic [SEQ_WIDTH-1:0] SEQ_LAST = 6'd32; // pause slot.

    // x^58 + x^39 + 1 scrambler.
    localparam int SCRAMBLER_WIDTH = 58;
    localparam int SCRAMBLER_TAP   = 39;
    localparam logic [SCRAMBLER_WIDTH-1:0] SCRAMBLER_SEED = '1;

    // one half of a 66-bit block as offered by the upstream source.
    // The header is only meaningful on the first half of a block.
    typedef struct packed {
        logic [HEADER_WIDTH-1:0] header;
        logic [DATA_WIDTH-1:0]   data;
    } tx_word_t;

    // sequence position and pause flag for the gearbox.
    typedef struct packed {
        logic [SEQ_WIDTH-1:0] seq;
        logic                 pause;
    } gearbox_ctrl_t;

endpackage

/* design/pcs_tx_top.sv */
`timescale 1ns/1ps

module pcs_tx_top (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  pcs_pkg::tx_word_t             i_word,
    output logic                          o_pause,
    output logic [pcs_pkg::DATA_WIDTH-1:0] o_data,
    output logic                          o_frame_word
);

    import pcs_pkg::*;

    logic          src_pause;      // shared by upstream and scrambler.
    gearbox_ctrl_t gearbox_ctrl;   // one cycle behind src_pause.
    tx_word_t      scrambled_word;

    gearbox_sequencer gearbox_sequencer_inst (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .o_pause (src_pause),
        .o_ctrl  (gearbox_ctrl)
    );

    tx_scrambler tx_scrambler_inst (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_pause (src_pause),
        .i_word  (i_word),
        .o_word  (scrambled_word)
    );

    tx_gearbox tx_gearbox_inst (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_word       (scrambled_word),
        .i_ctrl       (gearbox_ctrl),
        .o_data       (o_data),
        .o_frame_word (o_frame_word)
    );

    assign o_pause = src_pause;

endmodule

/* design/tx_gearbox.sv */
`timescale 1ns/1ps

module tx_gearbox (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  pcs_pkg::tx_word_t             i_word,
    input  pcs_pkg::gearbox_ctrl_t        i_ctrl,
    output logic [pcs_pkg::DATA_WIDTH-1:0] o_data,
    output logic                          o_frame_word
);

    import pcs_pkg::*;

    logic [BLOCK_WIDTH-1:0] buf_q;
    logic [BLOCK_WIDTH-1:0] buf_next;
    logic                   load_header;
    logic [SEQ_WIDTH:0]     header_idx;
    logic [SEQ_WIDTH:0]     data_idx;

    // even sequence is the first half of a block and carries the header.
    assign load_header  = ~i_ctrl.seq[0];
    assign o_frame_word = i_ctrl.seq[0]; // low on the header half.

    // The buffer fill grows by 2 bits every block, which is what
    // places the loads at seq and seq+1/seq+2.
    assign header_idx = {1'b0, i_ctrl.seq};
    assign data_idx   = load_header ? header_idx + 2'd2 : header_idx + 2'd1;

    always_comb begin
        buf_next = buf_q;
        buf_next[DATA_WIDTH-1:0] = buf_q[2*DATA_WIDTH-1:DATA_WIDTH]; // shift down one word.

        // pause slot only drains the residue.
        if (!i_ctrl.pause) begin
            for (int b = 0; b < BLOCK_WIDTH; b++) begin
                if (load_header && (b >= header_idx) && (b < header_idx + HEADER_WIDTH)) begin
                    buf_next[b] = i_word.header[b - header_idx];
                end
                if ((b >= data_idx) && (b < data_idx + DATA_WIDTH)) begin
                    buf_next[b] = i_word.data[b - data_idx];
                end
            end
        end
    end

    // line word leaves from the bottom of the updated buffer.
    assign o_data = buf_next[DATA_WIDTH-1:0];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            buf_q <= '0;
        end else begin
            buf_q <= buf_next;
        end
    end

    a_seq_in_range: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_ctrl.seq <= SEQ_LAST
    ) else $error("gearbox sequence beyond SEQ_LAST.");

    a_pause_only_last: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_ctrl.pause |-> (i_ctrl.seq == SEQ_LAST)
    ) else $error("gearbox paused outside the SEQ_LAST slot.");

    // after the pause slot the next block starts on a header half.
    a_restart_on_header: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_ctrl.pause |=> !o_frame_word
    ) else $error("block did not restart on the header half after pause.");

endmodule

/* design/tx_scrambler.sv */
`timescale 1ns/1ps

module tx_scrambler (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_pause,
    input  pcs_pkg::tx_word_t i_word,
    output pcs_pkg::tx_word_t o_word
);

    import pcs_pkg::*;

    // state[0] is the most recent scrambled bit, state[57] the oldest.
    logic [SCRAMBLER_WIDTH-1:0] state_q;
    logic [SCRAMBLER_WIDTH-1:0] state_next;
    logic [DATA_WIDTH-1:0]      scrambled;
    tx_word_t                   word_q;

    // Serial model unrolled over the 32 payload bits, LSB first.
    // Each bit sees the bits scrambled earlier in the same word.
    always_comb begin
        logic [SCRAMBLER_WIDTH-1:0] s;
        logic                       bit_out;
        s         = state_q;
        scrambled = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            bit_out      = i_word.data[i] ^ s[SCRAMBLER_TAP-1] ^ s[SCRAMBLER_WIDTH-1];
            scrambled[i] = bit_out;
            s            = {s[SCRAMBLER_WIDTH-2:0], bit_out}; // feed back scrambled bit.
        end
        state_next = s;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q <= SCRAMBLER_SEED;
        end else if (!i_pause) begin
            state_q <= state_next;
        end
    end

    // header goes straight through and is only delayed with the data.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            word_q <= '0;
        end else if (!i_pause) begin
            word_q.header <= i_word.header;
            word_q.data   <= scrambled;
        end
    end

    assign o_word = word_q;

    a_hold_on_pause: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_pause |=> ($stable(state_q) && $stable(o_word))
    ) else $error("scrambler advanced during a pause cycle.");

endmodule

/* dv/pcs_tx_tb.sv */
`timescale 1ns/1ps

module pcs_tx_tb;

    import pcs_pkg::*;

    localparam int    NUM_VECTORS   = 67;  // two sequencer periods plus the first cycle.
    localparam int    RESET_CYCLES  = 16;
    localparam int    RESET_TIMEOUT = 4;
    localparam string VECTOR_FILE   = "dv/pcs_tx_vectors.txt";

    // one line of the vector file.
    typedef struct packed {
        logic                  pause;
        tx_word_t              word;
        logic [DATA_WIDTH-1:0] line;
        logic                  frame;
    } vector_t;

    logic                  i_clk;
    logic                  i_reset;
    tx_word_t              i_word;
    logic                  o_pause;
    logic [DATA_WIDTH-1:0] o_data;
    logic                  o_frame_word;

    int check_count;
    int error_count;

    pcs_tx_top pcs_tx_top_inst (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_word       (i_word),
        .o_pause      (o_pause),
        .o_data       (o_data),
        .o_frame_word (o_frame_word)
    );

    always #4 i_clk = ~i_clk; // 8 ns period.

    task automatic check_value(
        input string                 name,
        input logic [DATA_WIDTH-1:0] expected,
        input logic [DATA_WIDTH-1:0] actual
    );
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s expected %h actual %h",
                     $time, name, expected, actual);
        end
    endtask

    // skips comment and blank lines; got stays low at end of file.
    task automatic read_vector(input int fd, output vector_t vec, output bit got);
        string       text;
        int          fields;
        logic [31:0] pause_f;
        logic [31:0] header_f;
        logic [31:0] data_f;
        logic [31:0] line_f;
        logic [31:0] frame_f;
        got = 1'b0;
        vec = '0;
        while (!got && !$feof(fd)) begin
            text = "";
            void'($fgets(text, fd));
            if (text.len() > 0 && text.getc(0) != "#") begin
                fields = $sscanf(text, "%h %h %h %h %h",
                                 pause_f, header_f, data_f, line_f, frame_f);
                if (fields == 5) begin
                    vec.pause       = pause_f[0];
                    vec.word.header = header_f[HEADER_WIDTH-1:0];
                    vec.word.data   = data_f[DATA_WIDTH-1:0];
                    vec.line        = line_f[DATA_WIDTH-1:0];
                    vec.frame       = frame_f[0];
                    got             = 1'b1;
                end
            end
        end
    endtask

    task automatic wait_reset_release(output bit released);
        int cycles;
        cycles = 0;
        @(negedge i_clk);
        while (i_reset !== 1'b0 && cycles < RESET_TIMEOUT) begin
            @(negedge i_clk);
            cycles++;
        end
        released = (i_reset === 1'b0);
    endtask

    initial begin : run_vectors
        int      fd;
        int      v;
        bit      got;
        bit      released;
        bit      stop;
        vector_t vec;
        i_clk       = 1'b0;
        i_reset     = 1'b1;
        i_word      = '0;
        check_count = 0;
        error_count = 0;
        stop        = 1'b0;
        v           = 0;

        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: could not open the vector file %s.", VECTOR_FILE);
            error_count++;
        end else begin
            // last reset edge is the first edge of the vector loop.
            repeat (RESET_CYCLES - 1) @(posedge i_clk);
            while (v < NUM_VECTORS && !stop) begin
                read_vector(fd, vec, got);
                if (!got) begin
                    $display("ERROR: vector file ended after %0d of %0d lines.",
                             v, NUM_VECTORS);
                    error_count++;
                    stop = 1'b1;
                end else begin
                    @(posedge i_clk);
                    i_reset <= 1'b0;
                    i_word  <= vec.word;
                    if (v == 0) begin
                        wait_reset_release(released);
                        if (!released) begin
                            $display("ERROR: reset was not released in time.");
                            error_count++;
                            stop = 1'b1;
                        end
                    end else begin
                        @(negedge i_clk); // outputs settled here.
                    end
                    if (!stop) begin
                        check_value("o_pause", vec.pause, o_pause);
                        check_value("o_data", vec.line, o_data);
                        check_value("o_frame_word", vec.frame, o_frame_word);
                    end
                    v++;
                end
            end
            $fclose(fd);
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* dv/pcs_tx_vectors.txt */
# columns in hex: pause header data line frame, one line per cycle after reset
# header and data are driven, pause line and frame are the expected outputs
0 1 FFFFFFFF 00000000 0
0 0 00000000 FFFFFFFD 0
0 2 03FFFF80 00000003 1
0 0 FFFFFFFF 00000008 0
0 1 03FFFF80 FFFFFFF0 1
0 0 FC00007F 0000001F 0
0 1 FC00007F FFFFFFC0 1
0 0 00000000 FFFFFF7F 0
0 2 FC00007F 000000FF 1
0 0 FC00007F FFFFFE00 0
0 1 FFFFFFFF FFFFFFFF 1
0 0 00000000 FFFFF7FF 0
0 2 03FFFF80 00000FFF 1
0 0 00000000 00002000 0
0 2 FFFFFFFF 00000000 1
0 0 03FFFF80 FFFF8000 0
0 1 03FFFF80 0000FFFF 1
0 0 FFFFFFFF 00010000 0
0 1 FC00007F FFFC0000 1
0 0 00000000 FFF7FFFF 0
0 1 FC00007F 000FFFFF 1
0 0 03FFFF80 FFD00000 0
0 2 03FFFF80 003FFFFF 1
0 0 FFFFFFFF 00800000 0
0 1 FC00007F FF000000 1
0 0 FFFFFFFF FDFFFFFF 0
0 2 00000000 FFFFFFFF 1
0 0 FC00007F 0BFFFFFF 0
0 1 03FFFF80 F0000000 1
0 0 03FFFF80 1FFFFFFF 0
0 1 00000000 00000000 1
0 0 00000000 40000000 0
1 0 00000000 00000000 1
0 2 00000000 00000000 0
0 0 FFFFFFFF 00000002 0
0 1 03FFFF80 FFFFFFFC 1
0 0 FC00007F 00000007 0
0 1 FC00007F FFFFFFF0 1
0 0 FFFFFFFF FFFFFFDF 0
0 2 00000000 FFFFFFFF 1
0 0 FC00007F 000000BF 0
0 1 FC00007F FFFFFF00 1
0 0 00000000 FFFFFDFF 0
0 1 03FFFF80 000003FF 1
0 0 FFFFFFFF 00000400 0
0 2 FC00007F FFFFF000 1
0 0 00000000 FFFFEFFF 0
0 1 FC00007F 00003FFF 1
0 0 03FFFF80 FFFF4000 0
0 2 03FFFF80 0000FFFF 1
0 0 00000000 00020000 0
0 2 FFFFFFFF 00000000 1
0 0 FC00007F FFF80000 0
0 1 FFFFFFFF FFFFFFFF 1
0 0 FFFFFFFF FFDFFFFF 0
0 1 00000000 FFFFFFFF 1
0 0 FC00007F 007FFFFF 0
0 2 03FFFF80 FF000000 1
0 0 FC00007F 02FFFFFF 0
0 1 FC00007F FC000000 1
0 0 00000000 F7FFFFFF 0
0 1 03FFFF80 0FFFFFFF 1
0 0 FFFFFFFF 10000000 0
0 2 03FFFF80 C0000000 1
0 0 FC00007F BFFFFFFF 0
1 0 FC00007F 00000000 1
0 1 00000000 FFFFFFFF 0

/* vlog.f */
design/pcs_pkg.sv
design/gearbox_sequencer.sv
design/tx_scrambler.sv
design/tx_gearbox.sv
design/pcs_tx_top.sv
dv/pcs_tx_tb.sv
